//--- fpu.f
+incdir+.
fpuPkg.sv
fpuUnpackAlign.sv
fpuAddNorm.sv
fpuRoundPack.sv
fpu.sv
fpuTb.sv

//--- Makefile
# Verilator build and run for the binary16 add/subtract pipeline

VERILATOR ?= verilator
TOP       ?= fpuTb
FILELIST  ?= fpu.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF "*** TEST PASSED ***" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- fpuTbVectors.svh
  // one row per request: operand a, operand b, operation, expected result, expected flags
  // flags are ordered Z, C, N, V from bit 3 down
  typedef struct packed {
    fpWord_t    a;
    fpWord_t    b;
    fpuOp_t     op;
    fpWord_t    result;
    condCodes_t flags;
  } vecRow_t;

  localparam int NumVectors = 26;

  vecRow_t vectors [NumVectors];

  task automatic setRow(input int idx, input fpWord_t a, input fpWord_t b, input fpuOp_t op,
                        input fpWord_t result, input condCodes_t flags);
    vectors[idx].a = a;
    vectors[idx].b = b;
    vectors[idx].op = op;
    vectors[idx].result = result;
    vectors[idx].flags = flags;
  endtask

  task automatic loadVectors();
    // exact sums and differences
    setRow(0, 16'h3C00, 16'h3C00, FPU_ADD, 16'h4000, 4'b0000);
    setRow(1, 16'h4200, 16'h3C00, FPU_SUB, 16'h4000, 4'b0000);
    setRow(2, 16'h3800, 16'h3400, FPU_ADD, 16'h3A00, 4'b0000);
    setRow(3, 16'h3C00, 16'hBC00, FPU_SUB, 16'h4000, 4'b0000);
    setRow(4, 16'h0800, 16'h0400, FPU_SUB, 16'h0400, 4'b0000);
    // cancellation and the sign of the result
    setRow(5, 16'h3C00, 16'h3C00, FPU_SUB, 16'h0000, 4'b1000);
    setRow(6, 16'h3C00, 16'h4200, FPU_SUB, 16'hC000, 4'b0010);
    setRow(7, 16'hC000, 16'h3C00, FPU_ADD, 16'hBC00, 4'b0010);
    setRow(8, 16'h8000, 16'h8000, FPU_ADD, 16'h8000, 4'b1010);
    // rounding: ties to even, sticky, below half and wide exponent gaps
    setRow(9, 16'h3C00, 16'h1000, FPU_ADD, 16'h3C00, 4'b0100);
    setRow(10, 16'h3C01, 16'h1000, FPU_ADD, 16'h3C02, 4'b0100);
    setRow(11, 16'h3C00, 16'h1001, FPU_ADD, 16'h3C01, 4'b0100);
    setRow(12, 16'h3C00, 16'h0C00, FPU_ADD, 16'h3C00, 4'b0100);
    setRow(13, 16'h4000, 16'h0400, FPU_ADD, 16'h4000, 4'b0100);
    setRow(14, 16'h7800, 16'h0400, FPU_ADD, 16'h7800, 4'b0100);
    setRow(15, 16'h4000, 16'h0400, FPU_SUB, 16'h4000, 4'b0100);
    // overflow, plain and caused by rounding
    setRow(16, 16'h7BFF, 16'h7BFF, FPU_ADD, 16'h7C00, 4'b0001);
    setRow(17, 16'h7BFF, 16'h4C00, FPU_ADD, 16'h7C00, 4'b0101);
    // infinities and NaN
    setRow(18, 16'h7C00, 16'h3C00, FPU_ADD, 16'h7C00, 4'b0000);
    setRow(19, 16'hFC00, 16'h3C00, FPU_ADD, 16'hFC00, 4'b0010);
    setRow(20, 16'h7C00, 16'h7C00, FPU_SUB, 16'h7E00, 4'b0000);
    setRow(21, 16'h3C00, 16'h7C00, FPU_SUB, 16'hFC00, 4'b0010);
    setRow(22, 16'h7C01, 16'h3C00, FPU_ADD, 16'h7C00, 4'b0000);
    // subnormal inputs and results flush to zero
    setRow(23, 16'h0001, 16'h3C00, FPU_ADD, 16'h3C00, 4'b0100);
    setRow(24, 16'h0200, 16'h0001, FPU_ADD, 16'h0000, 4'b1100);
    setRow(25, 16'h0401, 16'h0400, FPU_SUB, 16'h0000, 4'b1100);
  endtask

//--- fpuTb.sv
`timescale 1ns/1ps
`default_nettype none

module fpuTb import fpuPkg::*; ();

  localparam int ResetCycles = 8;

  logic     clk;
  logic     arstN;
  logic     reqValid;
  logic     reqReady;
  fpuReq_t  req;
  logic     respValid;
  logic     respReady;
  fpuResp_t resp;

  int errorCount;
  int sendIdx;
  int checkIdx;
  int cycleCount;
  int seed;

  `include "fpuTbVectors.svh"

  // reset, then about four cycles per row and stage, then some slack
  localparam int CycleLimit = ResetCycles + 3 * NumVectors * 4 + 50;

  fpu UUT (
    .clk       (clk),
    .arstN     (arstN),
    .reqValid  (reqValid),
    .reqReady  (reqReady),
    .req       (req),
    .respValid (respValid),
    .respReady (respReady),
    .resp      (resp)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic checkResponse(input int idx);
    assert (resp.result == vectors[idx].result) else begin
      errorCount++;
      $display("error at time %0t: resp.result (row %0d) expected %h, got %h",
               $time, idx, vectors[idx].result, resp.result);
    end
    assert (resp.flags == vectors[idx].flags) else begin
      errorCount++;
      $display("error at time %0t: resp.flags (row %0d) expected %b, got %b",
               $time, idx, vectors[idx].flags, resp.flags);
    end
  endtask

  // inputs change on falling edges and are sampled 1 ns later, well before the next rising edge
  initial begin : stimulus
    logic [31:0] coin;
    arstN = 1'b0;
    respReady = 1'b0;
    errorCount = 0;
    sendIdx = 0;
    checkIdx = 0;
    cycleCount = 0;
    seed = 75;
    loadVectors();

    // row 0 already waits at the input during reset, so a stage that ignored arstN would
    // let it through and fill up the pipeline
    reqValid = 1'b1;
    req.a = vectors[0].a;
    req.b = vectors[0].b;
    req.op = vectors[0].op;

    repeat (ResetCycles) begin
      @(negedge clk);
      cycleCount++;
      assert (!respValid) else begin
        errorCount++;
        $display("respValid went high while reset was asserted");
      end
    end
    arstN = 1'b1;
    #1;
    assert (reqReady) else begin
      errorCount++;
      $display("reqReady did not rise after reset was released");
    end
    if (reqValid && reqReady) begin
      sendIdx++;
    end

    while (checkIdx < NumVectors && cycleCount < CycleLimit) begin
      @(negedge clk);
      cycleCount++;
      // output stalls about a quarter of the time
      coin = $random(seed);
      respReady = (coin[1:0] != 2'b00);
      if (sendIdx < NumVectors) begin
        reqValid = 1'b1;
        req.a = vectors[sendIdx].a;
        req.b = vectors[sendIdx].b;
        req.op = vectors[sendIdx].op;
      end else begin
        reqValid = 1'b0;
        req = '0;
      end
      #1;
      if (respValid && respReady) begin
        checkResponse(checkIdx);
        checkIdx++;
      end
      if (reqValid && reqReady) begin
        sendIdx++;
      end
    end

    assert (checkIdx == NumVectors) else begin
      errorCount++;
      $display("timeout: only %0d of %0d responses arrived within %0d cycles",
               checkIdx, NumVectors, CycleLimit);
    end

    // with the table drained, nothing more may come out
    if (checkIdx == NumVectors) begin
      repeat (6) begin
        @(negedge clk);
        reqValid = 1'b0;
        respReady = 1'b1;
        #1;
        assert (!respValid) else begin
          errorCount++;
          $display("an extra response appeared after the last row was checked");
        end
      end
    end

    $display("summary: %0d errors, %0d of %0d responses checked",
             errorCount, checkIdx, NumVectors);
    if (errorCount == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule : fpuTb

`default_nettype wire

//--- fpu.sv
`timescale 1ns/1ps
`default_nettype none

module fpu import fpuPkg::*; (
  input  logic     clk,
  input  logic     arstN,
  input  logic     reqValid,
  output logic     reqReady,
  input  fpuReq_t  req,
  output logic     respValid,
  input  logic     respReady,
  output fpuResp_t resp
);

  logic        alignValid;
  logic        alignReady;
  alignStage_t align;
  logic        normValid;
  logic        normReady;
  normStage_t  norm;

  // three registered stages, ready ripples back through each one
  fpuUnpackAlign unpackAlign (
    .clk      (clk),
    .arstN    (arstN),
    .inValid  (reqValid),
    .inReady  (reqReady),
    .req      (req),
    .outValid (alignValid),
    .outReady (alignReady),
    .align    (align)
  );

  fpuAddNorm addNorm (
    .clk      (clk),
    .arstN    (arstN),
    .inValid  (alignValid),
    .inReady  (alignReady),
    .align    (align),
    .outValid (normValid),
    .outReady (normReady),
    .norm     (norm)
  );

  fpuRoundPack roundPack (
    .clk      (clk),
    .arstN    (arstN),
    .inValid  (normValid),
    .inReady  (normReady),
    .norm     (norm),
    .outValid (respValid),
    .outReady (respReady),
    .resp     (resp)
  );

endmodule : fpu

`default_nettype wire

//--- fpuRoundPack.sv
`timescale 1ns/1ps
`default_nettype none

module fpuRoundPack import fpuPkg::*; (
  input  logic       clk,
  input  logic       arstN,
  input  logic       inValid,
  output logic       inReady,
  input  normStage_t norm,
  output logic       outValid,
  input  logic       outReady,
  output fpuResp_t   resp
);

  localparam logic [ExpWidth-1:0] ExpOnes = '1;
  localparam fpExp_t ExpMax = fpExp_t'(2 * ExpBias + 1);

  logic                guardBit;
  logic                roundBit;
  logic                stickyBit;
  logic                roundUp;
  logic                inexact;
  logic [SigWidth+1:0] rounded;
  logic [SigWidth:0]   mant;
  fpExp_t              expRounded;
  logic                zFlag;
  logic                cFlag;
  logic                vFlag;
  fpWord_t             resultNext;

  assign guardBit = norm.sig[2];
  assign roundBit = norm.sig[1];
  assign stickyBit = norm.sig[0];

  // ties go to the even significand
  assign roundUp = guardBit && (roundBit || stickyBit || norm.sig[3]);
  assign inexact = guardBit || roundBit || stickyBit || norm.flushed;
  assign rounded = {1'b0, norm.sig[WorkWidth-1:3]} + (SigWidth + 2)'(roundUp);
  assign mant = rounded[SigWidth+1] ? rounded[SigWidth+1:1] : rounded[SigWidth:0];
  assign expRounded = norm.exp + fpExp_t'(rounded[SigWidth+1]);

  always_comb begin
    zFlag = 1'b0;
    cFlag = 1'b0;
    vFlag = 1'b0;
    resultNext = {norm.sign, expRounded[ExpWidth-1:0], mant[SigWidth-1:0]};
    case (norm.special)
      SPEC_NAN: resultNext = QuietNan;
      SPEC_INF: resultNext = {norm.sign, ExpOnes, {SigWidth{1'b0}}};
      default: begin
        if (norm.zero) begin
          resultNext = {norm.sign, {(BitWidth-1){1'b0}}};
          zFlag = 1'b1;
          cFlag = norm.flushed;
        end else if ($signed(expRounded) >= $signed(ExpMax)) begin
          resultNext = {norm.sign, ExpOnes, {SigWidth{1'b0}}};
          vFlag = 1'b1;
          cFlag = inexact;
        end else if ($signed(expRounded) <= 0) begin
          // too small for a normal number, flushed to zero
          resultNext = {norm.sign, {(BitWidth-1){1'b0}}};
          zFlag = 1'b1;
          cFlag = 1'b1;
        end else begin
          cFlag = inexact;
        end
      end
    endcase
  end

  assign inReady = !outValid || outReady;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      outValid <= 1'b0;
    end else if (inReady) begin
      outValid <= inValid;
    end
  end

  always_ff @(posedge clk) begin
    if (inValid && inReady) begin
      resp.result <= resultNext;
      resp.flags <= {zFlag, cFlag, resultNext[BitWidth-1], vFlag};
    end
  end

  noValidInReset: assert property (@(posedge clk) !arstN |-> !outValid);

endmodule : fpuRoundPack

`default_nettype wire

//--- fpuAddNorm.sv
`timescale 1ns/1ps
`default_nettype none

module fpuAddNorm import fpuPkg::*; (
  input  logic        clk,
  input  logic        arstN,
  input  logic        inValid,
  output logic        inReady,
  input  alignStage_t align,
  output logic        outValid,
  input  logic        outReady,
  output normStage_t  norm
);

  logic [WorkWidth:0] sum;
  logic [3:0]         lzc;
  normStage_t         normNext;

  // position of the highest set bit, counted from the hidden bit downwards
  function automatic logic [3:0] leadingZeros(input fpSig_t v);
    logic [3:0] n;
    n = 4'(WorkWidth);
    for (int i = 0; i < WorkWidth; i++) begin
      if (v[i]) begin
        n = 4'(WorkWidth - 1 - i);
      end
    end
    return n;
  endfunction

  // stage 1 put the larger magnitude first, so the difference never goes negative
  assign sum = align.effSub ? ({1'b0, align.bigSig} - {1'b0, align.smallSig})
                            : ({1'b0, align.bigSig} + {1'b0, align.smallSig});

  assign lzc = leadingZeros(sum[WorkWidth-1:0]);

  always_comb begin
    normNext.special = align.special;
    normNext.flushed = align.flushed;
    normNext.zero = 1'b0;
    normNext.sign = align.sign;
    normNext.exp = align.exp;
    normNext.sig = sum[WorkWidth-1:0];
    if (align.special != SPEC_NONE) begin
      normNext.sign = align.specSign;
      normNext.sig = align.bigSig;
    end else if (sum == '0) begin
      // exact cancellation gives +0, only -0 plus -0 keeps the sign
      normNext.zero = 1'b1;
      normNext.sign = align.effSub ? 1'b0 : align.sign;
      normNext.exp = '0;
    end else if (sum[WorkWidth]) begin
      // carry out, so shift right once and keep the lost bit in sticky
      normNext.exp = align.exp + fpExp_t'(1);
      normNext.sig = {sum[WorkWidth:2], sum[1] | sum[0]};
    end else begin
      normNext.exp = align.exp - fpExp_t'(lzc);
      normNext.sig = sum[WorkWidth-1:0] << lzc;
    end
  end

  assign inReady = !outValid || outReady;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      outValid <= 1'b0;
    end else if (inReady) begin
      outValid <= inValid;
    end
  end

  always_ff @(posedge clk) begin
    if (inValid && inReady) begin
      norm <= normNext;
    end
  end

  // relies on the magnitude ordering done in the stage before
  hiddenBitSet: assert property (@(posedge clk) disable iff (!arstN)
    outValid && !norm.zero && (norm.special == SPEC_NONE) |-> norm.sig[WorkWidth-1]);

endmodule : fpuAddNorm

`default_nettype wire

//--- fpuUnpackAlign.sv
`timescale 1ns/1ps
`default_nettype none

module fpuUnpackAlign import fpuPkg::*; (
  input  logic        clk,
  input  logic        arstN,
  input  logic        inValid,
  output logic        inReady,
  input  fpuReq_t     req,
  output logic        outValid,
  input  logic        outReady,
  output alignStage_t align
);

  localparam logic [ExpWidth-1:0] ExpOnes = '1;

  logic                  sA;
  logic                  sB;
  logic [ExpWidth-1:0]   eA;
  logic [ExpWidth-1:0]   eB;
  logic [SigWidth-1:0]   fA;
  logic [SigWidth-1:0]   fB;
  logic                  infA;
  logic                  infB;
  fpSig_t                sigA;
  fpSig_t                sigB;
  logic                  swap;
  logic [ExpWidth-1:0]   eBig;
  logic [ExpWidth-1:0]   eSmall;
  logic [ExpWidth-1:0]   expDiff;
  logic [3:0]            shiftAmt;
  fpSig_t                sigSmall;
  logic [2*WorkWidth-1:0] shifted;
  alignStage_t           alignNext;

  assign sA = req.a[BitWidth-1];
  // subtraction is addition with b's sign flipped
  assign sB = req.b[BitWidth-1] ^ (req.op == FPU_SUB);
  assign eA = req.a[BitWidth-2 -: ExpWidth];
  assign eB = req.b[BitWidth-2 -: ExpWidth];
  assign fA = req.a[SigWidth-1:0];
  assign fB = req.b[SigWidth-1:0];
  assign infA = (eA == ExpOnes);
  assign infB = (eB == ExpOnes);

  // a zero exponent means zero, so subnormals lose their fraction here
  assign sigA = (eA == '0) ? '0 : {1'b1, fA, 3'b000};
  assign sigB = (eB == '0) ? '0 : {1'b1, fB, 3'b000};

  assign swap = {eB, sigB} > {eA, sigA};
  assign eBig = swap ? eB : eA;
  assign eSmall = swap ? eA : eB;
  assign sigSmall = swap ? sigA : sigB;
  assign expDiff = eBig - eSmall;

  // past 15 places every bit of the smaller significand lands in sticky anyway
  assign shiftAmt = (expDiff > 5'd15) ? 4'd15 : expDiff[3:0];
  assign shifted = {sigSmall, {WorkWidth{1'b0}}} >> shiftAmt;

  always_comb begin
    alignNext.sign = swap ? sB : sA;
    alignNext.effSub = sA ^ sB;
    alignNext.exp = {2'b00, eBig};
    alignNext.bigSig = swap ? sigB : sigA;
    alignNext.smallSig = {shifted[2*WorkWidth-1:WorkWidth+1],
                          shifted[WorkWidth] | (|shifted[WorkWidth-1:0])};
    alignNext.flushed = ((eA == '0) && (fA != '0)) || ((eB == '0) && (fB != '0));
    alignNext.specSign = infA ? sA : sB;
    if (infA && infB && (sA != sB)) begin
      alignNext.special = SPEC_NAN;
    end else if (infA || infB) begin
      alignNext.special = SPEC_INF;
    end else begin
      alignNext.special = SPEC_NONE;
    end
  end

  assign inReady = !outValid || outReady;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      outValid <= 1'b0;
    end else if (inReady) begin
      outValid <= inValid;
    end
  end

  always_ff @(posedge clk) begin
    if (inValid && inReady) begin
      align <= alignNext;
    end
  end

  // a stalled item must not change under the downstream stage
  holdWhileStalled: assert property (@(posedge clk) disable iff (!arstN)
    outValid && !outReady |=> $stable(align));

endmodule : fpuUnpackAlign

`default_nettype wire

//--- fpuPkg.sv
`default_nettype none

package fpuPkg;

  // binary16 layout
  localparam int ExpWidth = 5;
  localparam int SigWidth = 10;
  localparam int BitWidth = 1 + ExpWidth + SigWidth;
  localparam int ExpBias = (1 << (ExpWidth - 1)) - 1;

  // working significand is the hidden bit, the fraction and guard, round, sticky
  localparam int WorkWidth = SigWidth + 4;

  typedef logic [BitWidth-1:0] fpWord_t;

  // two spare bits let normalization run past either end of the exponent range
  typedef logic [ExpWidth+1:0] fpExp_t;

  typedef logic [WorkWidth-1:0] fpSig_t;

  // ordered Z, C, N, V from bit 3 down
  typedef logic [3:0] condCodes_t;

  localparam fpWord_t QuietNan = 16'h7E00;

  typedef enum logic {
    FPU_ADD,
    FPU_SUB
  } fpuOp_t;

  typedef enum logic [1:0] {
    SPEC_NONE,
    SPEC_INF,
    SPEC_NAN
  } specialClass_t;

  typedef struct packed {
    fpWord_t a;
    fpWord_t b;
    fpuOp_t  op;
  } fpuReq_t;

  typedef struct packed {
    logic          sign;
    logic          effSub;
    fpExp_t        exp;
    fpSig_t        bigSig;
    fpSig_t        smallSig;
    logic          flushed;
    specialClass_t special;
    logic          specSign;
  } alignStage_t;

  typedef struct packed {
    logic          sign;
    fpExp_t        exp;
    fpSig_t        sig;
    logic          zero;
    logic          flushed;
    specialClass_t special;
  } normStage_t;

  typedef struct packed {
    fpWord_t    result;
    condCodes_t flags;
  } fpuResp_t;

endpackage : fpuPkg

`default_nettype wire
